// ==== hdl/vec_decoder.sv ====
module vec_decoder (
    input  vec_pkg::vec_instr_u   instr,
    input  logic                  instr_valid,
    input  vec_pkg::exec_stages_t stages,
    output vec_pkg::issue_ctrl_t  issue,
    output logic                  issue_valid,
    output logic                  stall
);

    import vec_pkg::*;

    logic [6:0]  opcode;
    logic [5:0]  funct6;
    logic [2:0]  funct3;
    logic [4:0]  dest;
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic [11:0] split_imm;
    logic [11:0] upper_imm;
    logic        accumulate;
    logic [4:0]  vs1_addr;
    logic [4:0]  vs2_addr;
    logic [4:0]  vs3_addr;
    logic [4:0]  func_sel;
    logic [4:0]  wb_sel;
    logic        is_store;
    logic        is_branch;
    logic        is_jump;
    logic        hazard_ex1;
    logic        hazard_ex2;
    logic        hazard_ex3;

    // True when any of the three sources matches the register a stage will write.
    function automatic logic reads_stage(
        input stage_ctrl_t s,
        input logic [4:0]  a1,
        input logic [4:0]  a2,
        input logic [4:0]  a3
    );
        logic match;
        match = (a1 == s.vd_addr) || (a2 == s.vd_addr) || (a3 == s.vd_addr);
        return s.valid && s.reg_we && match;
    endfunction

    assign opcode = instr.arith.opcode;
    assign funct6 = instr.arith.funct6;
    assign funct3 = instr.arith.funct3;
    assign dest   = instr.arith.vd;
    assign src1   = instr.arith.vs1;
    assign src2   = instr.arith.vs2;

    // Stores and branches split their offset around the rd field.
    assign split_imm = {instr.mem.imm_hi, instr.mem.imm_lo};
    assign upper_imm = {instr.mem.imm_hi, instr.mem.rs2};

    // The accumulate forms keep the addend in vd, so vd becomes a source.
    assign accumulate = (opcode == OP_V) &&
                        ((funct6 == VFMACC) || (funct6 == VFNMACC) ||
                         (funct6 == VFMSAC) || (funct6 == VFNMSAC));

    assign vs1_addr = src1;
    assign vs2_addr = accumulate ? dest : src2;
    assign vs3_addr = (opcode == OP_M) ? instr[31:27] :
                      accumulate       ? src2         : dest;

    always_comb begin
        func_sel = '0;
        case (opcode)
            OP_V: begin
                case (funct6)
                    VFADD:      func_sel = FADD;
                    VFSUB:      func_sel = FSUB;
                    VFMIN:      func_sel = FMIN;
                    VFMAX:      func_sel = FMAX;
                    VFSGNJ:     func_sel = FSGNJ;
                    VFSGNJN:    func_sel = FSGNJN;
                    VFSGNJX:    func_sel = FSGNJX;
                    VSLIDEUP:   func_sel = SLIDEUP;
                    VSLIDEDOWN: func_sel = SLIDEDOWN;
                    VMFEQ:      func_sel = FCMPEQ;
                    VMFLE:      func_sel = FCMPLE;
                    VMFLT:      func_sel = FCMPLT;
                    VFMUL:      func_sel = FMUL;
                    VFMADD:     func_sel = FMADD;
                    VFNMADD:    func_sel = FNMADD;
                    VFMSUB:     func_sel = FMSUB;
                    VFNMSUB:    func_sel = FNMSUB;
                    VFMACC:     func_sel = FMADD;
                    VFNMACC:    func_sel = FNMADD;
                    VFMSAC:     func_sel = FMSUB;
                    VFNMSAC:    func_sel = FNMSUB;
                    VSKEW:      func_sel = SKEW;
                    VTRANSPOSE: func_sel = TRANSPOSE;
                    VIDENTITY:  func_sel = IDENTITY;
                    VFUNARY0: begin
                        case (src1)
                            VFCVTXF: func_sel = FCVTWS;
                            VFCVTFX: func_sel = FCVTSW;
                            default: func_sel = '0;
                        endcase
                    end
                    VFUNARY1: begin
                        if (src1 == VFCLASS) begin
                            func_sel = FCLASS;
                        end
                    end
                    default:    func_sel = '0;
                endcase
            end
            BRANCH: begin
                case (funct3)
                    3'b000:  func_sel = FCMPEQ;
                    3'b100:  func_sel = FCMPLT;
                    default: func_sel = '0;
                endcase
            end
            default: func_sel = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            LOAD_FP: wb_sel = WB_LOAD;
            OP_V:    wb_sel = (func_sel[4:3] == 2'b00) ? WB_ALU : WB_FAST;
            OP_FP:   wb_sel = WB_FP;
            OP_M:    wb_sel = WB_MATRIX;
            BRANCH:  wb_sel = WB_FAST;
            default: wb_sel = '0;
        endcase
    end

    assign is_store  = (opcode == STORE_FP);
    assign is_branch = (opcode == BRANCH);
    assign is_jump   = (opcode == JALR);

    always_comb begin
        issue.vd_addr   = dest;
        issue.vs1_addr  = vs1_addr;
        issue.vs2_addr  = vs2_addr;
        issue.vs3_addr  = vs3_addr;
        issue.func_sel  = func_sel;
        issue.funct3    = funct3;
        issue.wb_sel    = wb_sel;
        issue.masking   = instr.arith.vm;
        issue.reg_we    = ~is_store & ~is_jump & ~is_branch;
        issue.jump      = is_jump;
        issue.branch    = is_branch;
        issue.mem_write = is_store;
        issue.mem_addr  = (is_branch || is_store) ? split_imm : upper_imm;
    end

    // A result in ex1 is only ready for the fast path. Ex2 has loads ready as
    // well, and by ex3 only the matrix unit is still busy.
    assign hazard_ex1 = reads_stage(stages.ex1, vs1_addr, vs2_addr, vs3_addr) &&
                        (|stages.ex1.wb_sel[4:1]);
    assign hazard_ex2 = reads_stage(stages.ex2, vs1_addr, vs2_addr, vs3_addr) &&
                        (|stages.ex2.wb_sel[4:2]);
    assign hazard_ex3 = reads_stage(stages.ex3, vs1_addr, vs2_addr, vs3_addr) &&
                        stages.ex3.wb_sel[4];

    assign stall       = instr_valid && (hazard_ex1 || hazard_ex2 || hazard_ex3);
    assign issue_valid = instr_valid && !stall;

endmodule

// ==== hdl/vec_exec_tracker.sv ====
module vec_exec_tracker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  vec_pkg::issue_ctrl_t  issue,
    output vec_pkg::exec_stages_t stages,
    output logic                  retire_valid,
    output logic [4:0]            retire_addr,
    output logic                  retire_we
);

    import vec_pkg::*;

    stage_ctrl_t ex1;
    stage_ctrl_t ex2;
    stage_ctrl_t ex3;
    stage_ctrl_t entry;

    // Only the fields the hazard check and the retire port need are kept.
    function automatic stage_ctrl_t make_entry(
        input logic        valid,
        input issue_ctrl_t ctrl
    );
        stage_ctrl_t e;
        e.valid   = valid;
        e.vd_addr = ctrl.vd_addr;
        e.reg_we  = ctrl.reg_we;
        e.wb_sel  = ctrl.wb_sel;
        return e;
    endfunction

    assign entry = make_entry(issue_valid, issue);

    always_ff @(posedge clk) begin
        if (reset) begin
            ex1.valid <= 1'b0;
            ex2.valid <= 1'b0;
            ex3.valid <= 1'b0;
        end else begin
            // A cycle without an issue pushes a bubble into ex1.
            ex1.valid <= entry.valid;
            ex2.valid <= ex1.valid;
            ex3.valid <= ex2.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex1.vd_addr <= entry.vd_addr;
        ex1.reg_we  <= entry.reg_we;
        ex1.wb_sel  <= entry.wb_sel;

        ex2.vd_addr <= ex1.vd_addr;
        ex2.reg_we  <= ex1.reg_we;
        ex2.wb_sel  <= ex1.wb_sel;

        ex3.vd_addr <= ex2.vd_addr;
        ex3.reg_we  <= ex2.reg_we;
        ex3.wb_sel  <= ex2.wb_sel;
    end

    assign stages.ex1 = ex1;
    assign stages.ex2 = ex2;
    assign stages.ex3 = ex3;

    // The instruction in ex3 leaves the pipeline at the next edge.
    assign retire_valid = ex3.valid;
    assign retire_addr  = ex3.vd_addr;
    assign retire_we    = ex3.reg_we;

endmodule

// ==== hdl/vec_issue_front.sv ====
module vec_issue_front (
    input  logic                 clk,
    input  logic                 reset,
    input  vec_pkg::vec_instr_u  instr,
    input  logic                 instr_valid,
    output logic                 stall,
    output logic                 issue_valid,
    output vec_pkg::issue_ctrl_t issue,
    output logic                 retire_valid,
    output logic [4:0]           retire_addr,
    output logic                 retire_we
);

    import vec_pkg::*;

    // Stage contents fed back from the tracker for the hazard check.
    exec_stages_t stages;

    vec_decoder u_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .stages      (stages),
        .issue       (issue),
        .issue_valid (issue_valid),
        .stall       (stall)
    );

    vec_exec_tracker u_tracker (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .stages       (stages),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_we    (retire_we)
    );

endmodule

// ==== hdl/vec_pkg.sv ====
package vec_pkg;

    // Major opcodes.
    localparam logic [6:0] OP_V     = 7'b1010111;
    localparam logic [6:0] OP_FP    = 7'b1010011;
    localparam logic [6:0] OP_M     = 7'b0001011;
    localparam logic [6:0] LOAD_FP  = 7'b0000111;
    localparam logic [6:0] STORE_FP = 7'b0100111;
    localparam logic [6:0] BRANCH   = 7'b1100011;
    localparam logic [6:0] JALR     = 7'b1100111;

    // Vector arithmetic funct6 codes.
    localparam logic [5:0] VFADD      = 6'b000000;
    localparam logic [5:0] VFSUB      = 6'b000010;
    localparam logic [5:0] VFMIN      = 6'b000100;
    localparam logic [5:0] VFMAX      = 6'b000110;
    localparam logic [5:0] VFSGNJ     = 6'b001000;
    localparam logic [5:0] VFSGNJN    = 6'b001001;
    localparam logic [5:0] VFSGNJX    = 6'b001010;
    localparam logic [5:0] VSLIDEUP   = 6'b001110;
    localparam logic [5:0] VSLIDEDOWN = 6'b001111;
    localparam logic [5:0] VFUNARY0   = 6'b010010;
    localparam logic [5:0] VFUNARY1   = 6'b010011;
    localparam logic [5:0] VMFEQ      = 6'b011000;
    localparam logic [5:0] VMFLE      = 6'b011001;
    localparam logic [5:0] VMFLT      = 6'b011011;
    localparam logic [5:0] VFMUL      = 6'b100100;
    localparam logic [5:0] VFMADD     = 6'b101000;
    localparam logic [5:0] VFNMADD    = 6'b101001;
    localparam logic [5:0] VFMSUB     = 6'b101010;
    localparam logic [5:0] VFNMSUB    = 6'b101011;
    localparam logic [5:0] VFMACC     = 6'b101100;
    localparam logic [5:0] VFNMACC    = 6'b101101;
    localparam logic [5:0] VFMSAC     = 6'b101110;
    localparam logic [5:0] VFNMSAC    = 6'b101111;
    localparam logic [5:0] VSKEW      = 6'b110000;
    localparam logic [5:0] VTRANSPOSE = 6'b110001;
    localparam logic [5:0] VIDENTITY  = 6'b110010;

    // Unary operations, selected by the vs1 field.
    localparam logic [4:0] VFCVTXF = 5'b00001;
    localparam logic [4:0] VFCVTFX = 5'b00011;
    localparam logic [4:0] VFCLASS = 5'b10000;

    // Functional unit selects. Codes 1 to 7 are the single-cycle units.
    localparam logic [4:0] FSGNJ     = 5'b00001;
    localparam logic [4:0] FSGNJN    = 5'b00010;
    localparam logic [4:0] FSGNJX    = 5'b00011;
    localparam logic [4:0] FCMPEQ    = 5'b00100;
    localparam logic [4:0] FCMPLE    = 5'b00101;
    localparam logic [4:0] FCMPLT    = 5'b00110;
    localparam logic [4:0] FCLASS    = 5'b00111;
    localparam logic [4:0] FMIN      = 5'b01000;
    localparam logic [4:0] FMAX      = 5'b01001;
    localparam logic [4:0] FADD      = 5'b01010;
    localparam logic [4:0] FSUB      = 5'b01011;
    localparam logic [4:0] FCVTWS    = 5'b01100;
    localparam logic [4:0] FCVTSW    = 5'b01101;
    localparam logic [4:0] SLIDEUP   = 5'b01110;
    localparam logic [4:0] SLIDEDOWN = 5'b01111;
    localparam logic [4:0] FMUL      = 5'b10000;
    localparam logic [4:0] FMADD     = 5'b10001;
    localparam logic [4:0] FNMADD    = 5'b10010;
    localparam logic [4:0] FMSUB     = 5'b10011;
    localparam logic [4:0] FNMSUB    = 5'b10100;
    localparam logic [4:0] SKEW      = 5'b11000;
    localparam logic [4:0] TRANSPOSE = 5'b11001;
    localparam logic [4:0] IDENTITY  = 5'b11010;

    // Writeback sources, one-hot, ordered by the stage that has the result.
    localparam logic [4:0] WB_FAST   = 5'b00001;
    localparam logic [4:0] WB_LOAD   = 5'b00010;
    localparam logic [4:0] WB_ALU    = 5'b00100;
    localparam logic [4:0] WB_FP     = 5'b01000;
    localparam logic [4:0] WB_MATRIX = 5'b10000;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } arith_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } mem_fmt_t;

    typedef union packed {
        arith_fmt_t arith;
        mem_fmt_t   mem;
    } vec_instr_u;

    typedef struct packed {
        logic [4:0]  vd_addr;
        logic [4:0]  vs1_addr;
        logic [4:0]  vs2_addr;
        logic [4:0]  vs3_addr;
        logic [4:0]  func_sel;
        logic [2:0]  funct3;
        logic [4:0]  wb_sel;
        logic        masking;
        logic        reg_we;
        logic        jump;
        logic        branch;
        logic        mem_write;
        logic [11:0] mem_addr;
    } issue_ctrl_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] vd_addr;
        logic       reg_we;
        logic [4:0] wb_sel;
    } stage_ctrl_t;

    typedef struct packed {
        stage_ctrl_t ex1;
        stage_ctrl_t ex2;
        stage_ctrl_t ex3;
    } exec_stages_t;

endpackage

// ==== project.f ====
hdl/vec_pkg.sv
hdl/vec_decoder.sv
hdl/vec_exec_tracker.sv
hdl/vec_issue_front.sv
verification/vec_issue_sva.sv
verification/vec_issue_checker.sv
verification/tb_vec_issue.sv

// ==== verification/tb_vec_issue.sv ====
module tb_vec_issue;

    import vec_pkg::*;

    localparam int RESET_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 20;

    logic        clk = 1'b0;
    logic        reset;
    vec_instr_u  instr;
    logic        instr_valid;
    logic        stall;
    logic        issue_valid;
    issue_ctrl_t issue;
    logic        retire_valid;
    logic [4:0]  retire_addr;
    logic        retire_we;

    logic        exp_valid;
    logic        exp_stall;
    issue_ctrl_t exp_ctrl;
    logic        line_end;
    int          line_no;
    int          error_count;
    int          pending;

    always #20 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
    end

    vec_issue_front u_vec_issue_front (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .stall        (stall),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_we    (retire_we)
    );

    vec_issue_checker u_checker (
        .clk          (clk),
        .reset        (reset),
        .exp_valid    (exp_valid),
        .exp_stall    (exp_stall),
        .exp_ctrl     (exp_ctrl),
        .line_end     (line_end),
        .line_no      (line_no),
        .stall        (stall),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_we    (retire_we),
        .error_count  (error_count),
        .pending      (pending)
    );

    initial begin
        int          fd;
        int          count;
        int          wait_cycles;
        int          tests;
        logic        aborted;
        string       text;
        issue_ctrl_t ctrl;
        logic [31:0] word;
        logic [31:0] f_valid;
        logic [31:0] hold;
        logic [31:0] f_func;
        logic [31:0] f_wb;
        logic [31:0] f_vs2;
        logic [31:0] f_vs3;
        logic [31:0] f_we;
        logic [31:0] f_jbm;
        logic [31:0] f_mem;
        instr       = '0;
        instr_valid = 1'b0;
        exp_valid   = 1'b0;
        exp_stall   = 1'b0;
        exp_ctrl    = '0;
        line_end    = 1'b0;
        line_no     = 0;
        tests       = 0;
        aborted     = 1'b0;

        wait_cycles = 0;
        while (reset !== 1'b0 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (reset !== 1'b0) begin
            $display("Reset was still high after %0d cycles", RESET_TIMEOUT);
            aborted = 1'b1;
        end
        fd = $fopen("verification/vec_issue_stim.txt", "r");
        if (fd == 0) begin
            $display("The stimulus file could not be opened");
            aborted = 1'b1;
        end

        if (!aborted) begin
            while (!$feof(fd)) begin
                count = $fgets(text, fd);
                if (count > 0 && text.getc(0) != "#") begin
                    count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h", word, f_valid,
                                    hold, f_func, f_wb, f_vs2, f_vs3, f_we, f_jbm, f_mem);
                    if (count == 10) begin
                        tests++;
                        ctrl          = '0;
                        ctrl.vd_addr  = word[11:7];
                        ctrl.vs1_addr = word[19:15];
                        ctrl.funct3   = word[14:12];
                        ctrl.masking  = word[25];
                        ctrl.func_sel = f_func[4:0];
                        ctrl.wb_sel   = f_wb[4:0];
                        ctrl.vs2_addr = f_vs2[4:0];
                        ctrl.vs3_addr = f_vs3[4:0];
                        ctrl.reg_we   = f_we[0];
                        {ctrl.jump, ctrl.branch, ctrl.mem_write} = f_jbm[2:0];
                        ctrl.mem_addr = f_mem[11:0];
                        // The word is held through its stall cycles and issues in the last one.
                        for (int c = 0; c <= hold; c++) begin
                            @(posedge clk);
                            instr       <= word;
                            instr_valid <= f_valid[0];
                            exp_valid   <= f_valid[0];
                            exp_stall   <= (c < hold);
                            exp_ctrl    <= ctrl;
                            line_end    <= (c == hold);
                            line_no     <= tests;
                        end
                    end
                end
            end
            $fclose(fd);

            @(posedge clk);
            instr_valid <= 1'b0;
            exp_valid   <= 1'b0;
            exp_stall   <= 1'b0;
            line_end    <= 1'b0;
            wait_cycles = 0;
            while (pending != 0 && wait_cycles < DRAIN_TIMEOUT) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (pending != 0) begin
                $display("%0d issued instructions never retired", pending);
                aborted = 1'b1;
            end
        end

        $display("%0d tests run, %0d errors", tests, error_count);
        if (!aborted && error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verification/vec_issue_checker.sv ====
module vec_issue_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 exp_valid,
    input  logic                 exp_stall,
    input  vec_pkg::issue_ctrl_t exp_ctrl,
    input  logic                 line_end,
    input  int                   line_no,
    input  logic                 stall,
    input  logic                 issue_valid,
    input  vec_pkg::issue_ctrl_t issue,
    input  logic                 retire_valid,
    input  logic [4:0]           retire_addr,
    input  logic                 retire_we,
    output int                   error_count,
    output int                   pending
);

    typedef struct packed {
        logic [31:0] due;
        logic [4:0]  vd_addr;
        logic        reg_we;
    } retire_entry_t;

    retire_entry_t expect_q[$];
    retire_entry_t entry;
    int            cycle;
    int            line_errors;

    task automatic compare(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
            line_errors++;
        end
    endtask

    // Outputs follow the inputs driven at the rising edge, so they are settled here.
    always @(negedge clk) begin
        if (reset) begin
            expect_q.delete();
            cycle       = 0;
            line_errors = 0;
        end else begin
            cycle++;
            compare("stall", stall, exp_stall);
            compare("issue_valid", issue_valid, exp_valid && !exp_stall);
            if (exp_valid) begin
                compare("vd_addr", issue.vd_addr, exp_ctrl.vd_addr);
                compare("vs1_addr", issue.vs1_addr, exp_ctrl.vs1_addr);
                compare("funct3", issue.funct3, exp_ctrl.funct3);
                compare("masking", issue.masking, exp_ctrl.masking);
                compare("func_sel", issue.func_sel, exp_ctrl.func_sel);
                compare("wb_sel", issue.wb_sel, exp_ctrl.wb_sel);
                compare("vs2_addr", issue.vs2_addr, exp_ctrl.vs2_addr);
                compare("vs3_addr", issue.vs3_addr, exp_ctrl.vs3_addr);
                compare("reg_we", issue.reg_we, exp_ctrl.reg_we);
                compare("jump", issue.jump, exp_ctrl.jump);
                compare("branch", issue.branch, exp_ctrl.branch);
                compare("mem_write", issue.mem_write, exp_ctrl.mem_write);
                compare("mem_addr", issue.mem_addr, exp_ctrl.mem_addr);
            end
            // An issue seen in this cycle leaves ex3 three cycles later.
            if (expect_q.size() > 0 && expect_q[0].due == cycle) begin
                entry = expect_q.pop_front();
                compare("retire_valid", retire_valid, 1'b1);
                compare("retire_addr", retire_addr, entry.vd_addr);
                compare("retire_we", retire_we, entry.reg_we);
            end else begin
                compare("retire_valid", retire_valid, 1'b0);
            end
            if (exp_valid && !exp_stall) begin
                entry.due     = cycle + 3;
                entry.vd_addr = exp_ctrl.vd_addr;
                entry.reg_we  = exp_ctrl.reg_we;
                expect_q.push_back(entry);
            end
            if (line_end) begin
                if (line_errors == 0) begin
                    $display("test %0d ok", line_no);
                end else begin
                    $display("test %0d failed with %0d mismatches", line_no, line_errors);
                end
                line_errors = 0;
            end
        end
        pending = expect_q.size();
    end

endmodule

// ==== verification/vec_issue_stim.txt ====
# instr valid hold func_sel wb_sel vs2 vs3 reg_we jbm(jump,branch,mem_write) mem_addr, all hex
# hold is the number of stall cycles expected before the word issues
00000000 0 0 00 00 00 00 0 0 000
00000000 0 0 00 00 00 00 0 0 000
000000d7 1 0 0a 01 00 01 1 0 000
20000157 1 0 01 04 00 02 1 0 200
6c0001d7 1 0 06 04 00 03 1 0 6c0
90000257 1 0 10 01 00 04 1 0 900
c00002d7 1 0 18 01 00 05 1 0 c00
48008357 1 0 0c 01 00 06 1 0 480
4c0803d7 1 0 07 04 00 07 1 0 4c0
b0900457 1 0 11 01 08 09 1 0 b09
5800050b 1 0 00 10 00 0b 1 0 580
00050657 1 3 0a 01 00 0c 1 0 000
280606d7 1 0 03 04 00 0d 1 0 280
18068757 1 2 09 01 00 0e 1 0 180
240002a7 1 0 00 00 00 05 0 1 245
02004363 1 0 06 01 00 06 0 2 026
00800067 1 0 00 00 08 00 0 4 008
00000063 1 0 04 01 00 00 0 2 000
01000787 1 0 00 02 10 0f 1 0 010
00000853 1 0 00 08 00 10 1 0 000
000808d7 1 2 0a 01 00 11 1 0 000

// ==== verification/vec_issue_sva.sv ====
module vec_issue_sva (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic issue_valid,
    input logic retire_valid
);

    // A stalled word is never counted as issued.
    stall_excludes_issue: assert property (
        @(posedge clk) disable iff (reset) !(stall && issue_valid)
    ) else $error("issue_valid and stall are high together");

    empty_after_reset: assert property (
        @(posedge clk) reset |=> !(retire_valid || stall)
    ) else $error("execute stages not empty in the cycle after reset");

    // Every issue retires exactly three cycles later, and nothing else retires.
    issue_retires: assert property (
        @(posedge clk) disable iff (reset) issue_valid |-> ##3 retire_valid
    ) else $error("issued instruction did not retire three cycles later");

    retire_has_issue: assert property (
        @(posedge clk) disable iff (reset) retire_valid |-> $past(issue_valid, 3)
    ) else $error("retire without an issue three cycles earlier");

endmodule

bind vec_issue_front vec_issue_sva u_sva (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .issue_valid  (issue_valid),
    .retire_valid (retire_valid)
);
